//--- filelist.f
logic/mmu_pkg.sv
logic/tlb_entry_array.sv
logic/tlb_random_counter.sv
logic/tlb_ctrl_fsm.sv
logic/tlb_translate.sv
logic/phys_addr_decode.sv
logic/mmu_top.sv
dv/mmu_asserts.sv
dv/tb_mmu.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_mmu
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q ">>> PASS" $(LOG) || { echo "simulation ended without passing"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/tb_mmu.sv
`timescale 1ns/1ps

module tb_mmu;

	import mmu_pkg::*;

	localparam int TLB_ENTRIES = 16;
	localparam int IDX_W = $clog2(TLB_ENTRIES);
	localparam int RESP_W = ADDR_W + 5;
	// The longest test takes a few hundred cycles, so this leaves a wide margin.
	localparam int MAX_CYCLES = 2000;

	localparam logic [31:0] DEV_ADDRS [16] = '{
		32'h0000_0000, 32'h007f_fffc, 32'h0080_0000, 32'h1fc0_0000,
		32'h1fc0_0ffc, 32'h1fc0_1000, 32'h1e00_0000, 32'h1eff_ffff,
		32'h1a09_6000, 32'h1a09_6004, 32'h1fd0_03f8, 32'h1fd0_03fc,
		32'h1fd0_0400, 32'h0f00_0000, 32'h0f00_0004, 32'h19ff_fffc
	};

	logic               clk = 1'b0;
	logic               rst;
	logic               req_valid;
	logic [ADDR_W-1:0]  vaddr;
	logic               write;
	logic               resp_valid;
	logic [ADDR_W-1:0]  paddr;
	tlb_exc_e           exc;
	dev_sel_e           dev_sel;
	logic               op_valid;
	tlb_op_e            op;
	logic [IDX_W-1:0]   op_index;
	logic [VPN2_W-1:0]  op_hi;
	logic [ENTRY_W-1:0] op_data;
	logic               op_done;
	logic               probe_hit;
	logic [IDX_W-1:0]   probe_index;

	logic [ENTRY_W-1:0] model_entries [TLB_ENTRIES];
	logic [IDX_W-1:0]   model_wired;
	logic [IDX_W-1:0]   model_random;
	logic [RESP_W-1:0]  exp_q [$];
	logic [RESP_W-1:0]  resp_expected;
	int                 cycle_count = 0;

	mmu_top #(.TLB_ENTRIES(TLB_ENTRIES)) u_mmu_top (
		.clk         (clk),
		.rst         (rst),
		.req_valid   (req_valid),
		.vaddr       (vaddr),
		.write       (write),
		.resp_valid  (resp_valid),
		.paddr       (paddr),
		.exc         (exc),
		.dev_sel     (dev_sel),
		.op_valid    (op_valid),
		.op          (op),
		.op_index    (op_index),
		.op_hi       (op_hi),
		.op_data     (op_data),
		.op_done     (op_done),
		.probe_hit   (probe_hit),
		.probe_index (probe_index)
	);

	always #50 clk = ~clk;

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic compare_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp)
			else stop_with_failure($sformatf("mismatch %s: got 0x%0h expected 0x%0h",
				name, got, exp));
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		assert (cycle_count < MAX_CYCLES)
			else stop_with_failure("timeout: the tests did not finish within the cycle limit");
	end

	function automatic logic [ENTRY_W-1:0] make_entry(input logic [VPN2_W-1:0] vpn2,
		input logic [PFN_W-1:0] pfn1, input logic d1, input logic [PFN_W-1:0] pfn0,
		input logic d0);
		logic [ENTRY_W-1:0] e;
		e = '0;
		e[VPN2_HI:VPN2_LO] = vpn2;
		e[PFN1_HI:PFN1_LO] = pfn1;
		e[D1_BIT] = d1;
		e[PFN0_HI:PFN0_LO] = pfn0;
		e[D0_BIT] = d0;
		return e;
	endfunction

	// Searches from the top so that the highest matching index is found first.
	function automatic int model_lookup(input logic [VPN2_W-1:0] vpn2);
		for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
			if (model_entries[i][VPN2_HI:VPN2_LO] == vpn2) begin
				return i;
			end
		end
		return -1;
	endfunction

	function automatic dev_sel_e decode_device(input logic [31:0] a);
		if (a < 32'h0080_0000) begin
			return DEV_RAM;
		end
		if (a >= 32'h1fc0_0000 && a < 32'h1fc0_1000) begin
			return DEV_ROM;
		end
		if ((a >= 32'h1e00_0000 && a < 32'h1f00_0000) ||
			(a >= 32'h1a00_0000 && a <= 32'h1a09_6000)) begin
			return DEV_FLASH;
		end
		case (a)
			32'h1fd0_03f8: return DEV_UART;
			32'h1fd0_03fc: return DEV_UART_STAT;
			32'h1fd0_0400: return DEV_DIGSEG;
			32'h0f00_0000: return DEV_PS2;
			default:       return DEV_NONE;
		endcase
	endfunction

	function automatic logic [RESP_W-1:0] predict_response(input logic [31:0] va,
		input logic wr);
		logic [31:0]        pa;
		tlb_exc_e           ex;
		logic [ENTRY_W-1:0] e;
		logic [PFN_W-1:0]   frame;
		logic               dirty;
		int                 hit_idx;
		pa = '0;
		ex = EXC_NONE;
		if (va[31:30] == 2'b10) begin
			pa = {2'b00, va[29:0]};
		end else begin
			hit_idx = model_lookup(va[31:13]);
			if (hit_idx < 0) begin
				ex = wr ? EXC_TLBS : EXC_TLBL;
			end else begin
				e = model_entries[hit_idx];
				frame = va[12] ? e[PFN1_HI:PFN1_LO] : e[PFN0_HI:PFN0_LO];
				dirty = va[12] ? e[D1_BIT] : e[D0_BIT];
				pa = {frame, va[11:0]};
				if (wr && !dirty) begin
					ex = EXC_MOD;
				end
			end
		end
		return {pa, ex, decode_device(pa)};
	endfunction

	// Every response is matched in order against the oldest outstanding prediction.
	always @(negedge clk) begin
		if (!rst && resp_valid === 1'b1) begin
			assert (exp_q.size() != 0)
				else stop_with_failure("a response arrived with no request outstanding");
			resp_expected = exp_q.pop_front();
			compare_value("paddr", 64'(paddr), 64'(resp_expected[RESP_W-1:5]));
			compare_value("exc", 64'(exc), 64'(resp_expected[4:3]));
			compare_value("dev_sel", 64'(dev_sel), 64'(resp_expected[2:0]));
		end
	end

	task automatic send_req(input logic [31:0] va, input logic wr);
		@(posedge clk);
		#1;
		req_valid = 1'b1;
		vaddr = va;
		write = wr;
		exp_q.push_back(predict_response(va, wr));
	endtask

	task automatic drain_reqs();
		@(posedge clk);
		#1;
		req_valid = 1'b0;
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
	endtask

	task automatic issue_op(input tlb_op_e kind, input logic [IDX_W-1:0] index,
		input logic [VPN2_W-1:0] hi, input logic [ENTRY_W-1:0] data);
		int wait_cycles;
		int hit_idx;
		@(posedge clk);
		#1;
		op_valid = 1'b1;
		op = kind;
		op_index = index;
		op_hi = hi;
		op_data = data;
		@(posedge clk);
		#1;
		op_valid = 1'b0;
		wait_cycles = 0;
		@(negedge clk);
		while (op_done !== 1'b1 && wait_cycles < 8) begin
			@(negedge clk);
			wait_cycles++;
		end
		assert (op_done === 1'b1)
			else stop_with_failure("op_done did not arrive after a TLB operation");
		case (kind)
			TLB_OP_WI: model_entries[index] = data;
			TLB_OP_WR: begin
				model_entries[model_random] = data;
				if (model_random <= model_wired) begin
					model_random = IDX_W'(TLB_ENTRIES - 1);
				end else begin
					model_random = model_random - 1'b1;
				end
			end
			TLB_OP_P: begin
				hit_idx = model_lookup(hi);
				compare_value("probe_hit", 64'(probe_hit), 64'(hit_idx >= 0));
				if (hit_idx >= 0) begin
					compare_value("probe_index", 64'(probe_index), 64'(hit_idx));
				end
			end
			default: begin
				model_wired = hi[IDX_W-1:0];
				model_random = IDX_W'(TLB_ENTRIES - 1);
			end
		endcase
	endtask

	// After reset every entry holds VPN2 zero with clean frames at zero.
	task automatic unmapped_and_reset();
		send_req(32'h8000_1234, 1'b0);
		send_req(32'h9fc0_0100, 1'b0);
		send_req(32'h9fd0_03f8, 1'b1);
		send_req(32'hbfff_fffc, 1'b0);
		send_req(32'h0000_0abc, 1'b0);
		send_req(32'h0000_1010, 1'b1);
		drain_reqs();
	endtask

	task automatic indexed_writes();
		logic [VPN2_W-1:0] vpn2 [8];
		for (int i = 0; i < 8; i++) begin
			vpn2[i] = {2'b00, 13'($urandom()), 4'(i)};
			issue_op(TLB_OP_WI, IDX_W'(i), '0, make_entry(vpn2[i], 20'($urandom()),
				1'(i), 20'($urandom()), 1'(i >> 1)));
		end
		for (int i = 0; i < 8; i++) begin
			send_req({vpn2[i], 1'b0, 12'($urandom())}, 1'b0);
			send_req({vpn2[i], 1'b0, 12'($urandom())}, 1'b1);
			send_req({vpn2[i], 1'b1, 12'($urandom())}, 1'b0);
			send_req({vpn2[i], 1'b1, 12'($urandom())}, 1'b1);
		end
		drain_reqs();
	endtask

	task automatic miss_and_priority();
		send_req(32'h4000_0000, 1'b0);
		send_req(32'h5abc_d123, 1'b1);
		send_req(32'hc000_1ffc, 1'b1);
		send_req(32'hfff0_0010, 1'b0);
		drain_reqs();
		issue_op(TLB_OP_WI, IDX_W'(3), '0,
			make_entry(19'h3_0005, 20'h1_1111, 1'b1, 20'h1_1110, 1'b1));
		issue_op(TLB_OP_WI, IDX_W'(12), '0,
			make_entry(19'h3_0005, 20'h0_2222, 1'b0, 20'h0_2220, 1'b1));
		send_req({19'h3_0005, 1'b0, 12'h044}, 1'b0);
		send_req({19'h3_0005, 1'b1, 12'h088}, 1'b1);
		drain_reqs();
	endtask

	task automatic device_decode();
		logic [VPN2_W-1:0] vpn2;
		logic [31:0]       pa;
		for (int k = 0; k < 16; k++) begin
			vpn2 = 19'h6_0000 + 19'(k);
			pa = DEV_ADDRS[k];
			issue_op(TLB_OP_WI, IDX_W'(6), '0,
				make_entry(vpn2, pa[31:12], 1'b1, pa[31:12], 1'b1));
			send_req({vpn2, 1'(k), pa[11:0]}, 1'b0);
			drain_reqs();
		end
	endtask

	// With wired at 10 the indices run 15 down to 10 and wrap back to 15.
	task automatic random_and_wired();
		logic [VPN2_W-1:0] vpn2 [8];
		// An early write-random moves the counter, so the wired write has to reload it.
		issue_op(TLB_OP_WR, '0, '0, make_entry(19'h5_5555, 20'h0_0abc, 1'b1,
			20'h0_0abd, 1'b1));
		issue_op(TLB_OP_WIRED, '0, 19'd10, '0);
		for (int k = 0; k < 8; k++) begin
			vpn2[k] = {2'b01, 13'($urandom()), 4'(k)};
			issue_op(TLB_OP_WR, '0, '0, make_entry(vpn2[k], 20'($urandom()), 1'b1,
				20'($urandom()), 1'b0));
		end
		for (int k = 0; k < 8; k++) begin
			issue_op(TLB_OP_P, '0, vpn2[k], '0);
		end
		issue_op(TLB_OP_P, '0, 19'h7_ffff, '0);
		send_req({vpn2[7], 1'b1, 12'h3f0}, 1'b1);
		send_req({vpn2[6], 1'b0, 12'h004}, 1'b1);
		drain_reqs();
	endtask

	initial begin
		void'($urandom(5));
		rst = 1'b1;
		req_valid = 1'b0;
		vaddr = '0;
		write = 1'b0;
		op_valid = 1'b0;
		op = TLB_OP_WI;
		op_index = '0;
		op_hi = '0;
		op_data = '0;
		for (int i = 0; i < TLB_ENTRIES; i++) begin
			model_entries[i] = '0;
		end
		model_wired = '0;
		model_random = IDX_W'(TLB_ENTRIES - 1);
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		unmapped_and_reset();
		indexed_writes();
		miss_and_priority();
		device_decode();
		random_and_wired();
		repeat (4) @(posedge clk);
		$display(">>> PASS");
		$finish;
	end

endmodule

//--- dv/mmu_asserts.sv
`timescale 1ns/1ps

module mmu_asserts (
	input logic clk,
	input logic rst,
	input logic req_valid,
	input logic resp_valid,
	input logic op_valid,
	input logic op_done
);

	// Two register stages sit between a request and its response.
	resp_latency: assert property (@(posedge clk) disable iff (rst)
		resp_valid == $past(req_valid, 2))
		else $error("resp_valid does not follow req_valid by exactly two cycles");

	op_latency: assert property (@(posedge clk) disable iff (rst)
		op_done == $past(op_valid, 2))
		else $error("op_done does not follow op_valid by exactly two cycles");

	// The FSM ignores a strobe while it is still busy with the previous operation.
	op_spacing: assert property (@(posedge clk) disable iff (rst)
		op_valid |-> !$past(op_valid, 1) && !$past(op_valid, 2))
		else $error("op_valid arrived while an operation was still busy");

endmodule

bind mmu_top mmu_asserts u_mmu_asserts (
	.clk        (clk),
	.rst        (rst),
	.req_valid  (req_valid),
	.resp_valid (resp_valid),
	.op_valid   (op_valid),
	.op_done    (op_done)
);

//--- logic/mmu_top.sv
`timescale 1ns/1ps

module mmu_top #(
	parameter int TLB_ENTRIES = 16,
	localparam int IDX_W = $clog2(TLB_ENTRIES)
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        req_valid,
	input  logic [mmu_pkg::ADDR_W-1:0]  vaddr,
	input  logic                        write,
	output logic                        resp_valid,
	output logic [mmu_pkg::ADDR_W-1:0]  paddr,
	output mmu_pkg::tlb_exc_e           exc,
	output mmu_pkg::dev_sel_e           dev_sel,
	input  logic                        op_valid,
	input  mmu_pkg::tlb_op_e            op,
	input  logic [IDX_W-1:0]            op_index,
	input  logic [mmu_pkg::VPN2_W-1:0]  op_hi,
	input  logic [mmu_pkg::ENTRY_W-1:0] op_data,
	output logic                        op_done,
	output logic                        probe_hit,
	output logic [IDX_W-1:0]            probe_index
);

	import mmu_pkg::*;

	logic               we;
	logic [IDX_W-1:0]   w_index;
	logic [ENTRY_W-1:0] w_data;
	logic [VPN2_W-1:0]  lookup_vpn2;
	logic [VPN2_W-1:0]  probe_vpn2;
	logic               match_hit;
	logic [ENTRY_W-1:0] match_entry;
	logic               arr_probe_hit;
	logic [IDX_W-1:0]   arr_probe_index;
	logic               wired_we;
	logic [IDX_W-1:0]   wired_value;
	logic               advance;
	logic [IDX_W-1:0]   random_index;
	logic               s1_valid;
	logic [ADDR_W-1:0]  s1_paddr;
	tlb_exc_e           s1_exc;

	tlb_entry_array #(.TLB_ENTRIES(TLB_ENTRIES)) u_tlb_entry_array (
		.clk         (clk),
		.rst         (rst),
		.we          (we),
		.w_index     (w_index),
		.w_data      (w_data),
		.lookup_vpn2 (lookup_vpn2),
		.probe_vpn2  (probe_vpn2),
		.match_hit   (match_hit),
		.match_index (),
		.match_entry (match_entry),
		.probe_hit   (arr_probe_hit),
		.probe_index (arr_probe_index)
	);

	tlb_random_counter #(.TLB_ENTRIES(TLB_ENTRIES)) u_tlb_random_counter (
		.clk          (clk),
		.rst          (rst),
		.wired_we     (wired_we),
		.wired_value  (wired_value),
		.advance      (advance),
		.random_index (random_index)
	);

	tlb_ctrl_fsm #(.TLB_ENTRIES(TLB_ENTRIES)) u_tlb_ctrl_fsm (
		.clk            (clk),
		.rst            (rst),
		.op_valid       (op_valid),
		.op             (op),
		.op_index       (op_index),
		.op_hi          (op_hi),
		.op_data        (op_data),
		.random_index   (random_index),
		.probe_hit_in   (arr_probe_hit),
		.probe_index_in (arr_probe_index),
		.we             (we),
		.w_index        (w_index),
		.w_data         (w_data),
		.probe_vpn2     (probe_vpn2),
		.wired_we       (wired_we),
		.wired_value    (wired_value),
		.advance        (advance),
		.op_done        (op_done),
		.probe_hit      (probe_hit),
		.probe_index    (probe_index)
	);

	tlb_translate u_tlb_translate (
		.clk         (clk),
		.rst         (rst),
		.req_valid   (req_valid),
		.vaddr       (vaddr),
		.write       (write),
		.match_hit   (match_hit),
		.match_entry (match_entry),
		.lookup_vpn2 (lookup_vpn2),
		.s1_valid    (s1_valid),
		.s1_paddr    (s1_paddr),
		.s1_exc      (s1_exc)
	);

	phys_addr_decode u_phys_addr_decode (
		.clk        (clk),
		.rst        (rst),
		.s1_valid   (s1_valid),
		.s1_paddr   (s1_paddr),
		.s1_exc     (s1_exc),
		.resp_valid (resp_valid),
		.paddr      (paddr),
		.exc        (exc),
		.dev_sel    (dev_sel)
	);

endmodule

//--- logic/phys_addr_decode.sv
`timescale 1ns/1ps

module phys_addr_decode (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       s1_valid,
	input  logic [mmu_pkg::ADDR_W-1:0] s1_paddr,
	input  mmu_pkg::tlb_exc_e          s1_exc,
	output logic                       resp_valid,
	output logic [mmu_pkg::ADDR_W-1:0] paddr,
	output mmu_pkg::tlb_exc_e          exc,
	output mmu_pkg::dev_sel_e          dev_sel
);

	import mmu_pkg::*;

	dev_sel_e dev_next;

	// First match wins; the second FLASH window ends on an odd boundary.
	always_comb begin
		if (s1_paddr <= 32'h007f_ffff) begin
			dev_next = DEV_RAM;
		end else if (s1_paddr >= 32'h1fc0_0000 && s1_paddr <= 32'h1fc0_0fff) begin
			dev_next = DEV_ROM;
		end else if (s1_paddr >= 32'h1e00_0000 && s1_paddr <= 32'h1eff_ffff) begin
			dev_next = DEV_FLASH;
		end else if (s1_paddr >= 32'h1a00_0000 && s1_paddr <= 32'h1a09_6000) begin
			dev_next = DEV_FLASH;
		end else if (s1_paddr == 32'h1fd0_03f8) begin
			dev_next = DEV_UART;
		end else if (s1_paddr == 32'h1fd0_03fc) begin
			dev_next = DEV_UART_STAT;
		end else if (s1_paddr == 32'h1fd0_0400) begin
			dev_next = DEV_DIGSEG;
		end else if (s1_paddr == 32'h0f00_0000) begin
			dev_next = DEV_PS2;
		end else begin
			dev_next = DEV_NONE;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			paddr   <= s1_paddr;
			exc     <= s1_exc;
			dev_sel <= dev_next;
		end
	end

endmodule

//--- logic/tlb_translate.sv
`timescale 1ns/1ps

module tlb_translate (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        req_valid,
	input  logic [mmu_pkg::ADDR_W-1:0]  vaddr,
	input  logic                        write,
	input  logic                        match_hit,
	input  logic [mmu_pkg::ENTRY_W-1:0] match_entry,
	output logic [mmu_pkg::VPN2_W-1:0]  lookup_vpn2,
	output logic                        s1_valid,
	output logic [mmu_pkg::ADDR_W-1:0]  s1_paddr,
	output mmu_pkg::tlb_exc_e           s1_exc
);

	import mmu_pkg::*;

	logic              unmapped;
	logic [PFN_W-1:0]  pfn;
	logic              dirty;
	logic [ADDR_W-1:0] paddr_next;
	tlb_exc_e          exc_next;

	assign lookup_vpn2 = vaddr[ADDR_W-1 -: VPN2_W];

	// The kseg0/kseg1 style window bypasses the TLB.
	assign unmapped = (vaddr[ADDR_W-1 -: 2] == 2'b10);

	// Bit 12 selects the odd page of the pair.
	always_comb begin
		if (vaddr[OFFSET_W]) begin
			pfn   = match_entry[PFN1_HI:PFN1_LO];
			dirty = match_entry[D1_BIT];
		end else begin
			pfn   = match_entry[PFN0_HI:PFN0_LO];
			dirty = match_entry[D0_BIT];
		end
	end

	always_comb begin
		paddr_next = '0;
		exc_next   = EXC_NONE;
		if (unmapped) begin
			paddr_next = {2'b00, vaddr[ADDR_W-3:0]};
		end else if (match_hit) begin
			paddr_next = {pfn, vaddr[OFFSET_W-1:0]};
			if (write && !dirty) begin
				exc_next = EXC_MOD;
			end
		end else if (write) begin
			exc_next = EXC_TLBS;
		end else begin
			exc_next = EXC_TLBL;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= req_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid) begin
			s1_paddr <= paddr_next;
			s1_exc   <= exc_next;
		end
	end

endmodule

//--- logic/tlb_ctrl_fsm.sv
`timescale 1ns/1ps

module tlb_ctrl_fsm #(
	parameter int TLB_ENTRIES = 16,
	localparam int IDX_W = $clog2(TLB_ENTRIES)
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        op_valid,
	input  mmu_pkg::tlb_op_e            op,
	input  logic [IDX_W-1:0]            op_index,
	input  logic [mmu_pkg::VPN2_W-1:0]  op_hi,
	input  logic [mmu_pkg::ENTRY_W-1:0] op_data,
	input  logic [IDX_W-1:0]            random_index,
	input  logic                        probe_hit_in,
	input  logic [IDX_W-1:0]            probe_index_in,
	output logic                        we,
	output logic [IDX_W-1:0]            w_index,
	output logic [mmu_pkg::ENTRY_W-1:0] w_data,
	output logic [mmu_pkg::VPN2_W-1:0]  probe_vpn2,
	output logic                        wired_we,
	output logic [IDX_W-1:0]            wired_value,
	output logic                        advance,
	output logic                        op_done,
	output logic                        probe_hit,
	output logic [IDX_W-1:0]            probe_index
);

	import mmu_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		WRITE,
		PROBE,
		WIRED,
		DONE
	} state_e;

	state_e               state;
	tlb_op_e              op_q;
	logic [IDX_W-1:0]     index_q;
	logic [VPN2_W-1:0]    hi_q;
	logic [ENTRY_W-1:0]   data_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			op_q  <= TLB_OP_WI;
		end else begin
			case (state)
				IDLE: begin
					if (op_valid) begin
						op_q <= op;
						case (op)
							TLB_OP_WI, TLB_OP_WR: state <= WRITE;
							TLB_OP_P:             state <= PROBE;
							default:              state <= WIRED;
						endcase
					end
				end
				WRITE, PROBE, WIRED: state <= DONE;
				default:             state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && op_valid) begin
			index_q <= op_index;
			hi_q    <= op_hi;
			data_q  <= op_data;
		end
	end

	// The probe result is held so that it lines up with op_done.
	always_ff @(posedge clk) begin
		if (rst) begin
			probe_hit <= 1'b0;
		end else if (state == PROBE) begin
			probe_hit <= probe_hit_in;
		end
	end

	always_ff @(posedge clk) begin
		if (state == PROBE) begin
			probe_index <= probe_index_in;
		end
	end

	assign we          = (state == WRITE);
	assign w_index     = (op_q == TLB_OP_WR) ? random_index : index_q;
	assign w_data      = data_q;
	assign advance     = (state == WRITE) && (op_q == TLB_OP_WR);
	assign probe_vpn2  = hi_q;
	assign wired_we    = (state == WIRED);
	assign wired_value = hi_q[IDX_W-1:0];
	assign op_done     = (state == DONE);

endmodule

//--- logic/tlb_random_counter.sv
`timescale 1ns/1ps

module tlb_random_counter #(
	parameter int TLB_ENTRIES = 16,
	localparam int IDX_W = $clog2(TLB_ENTRIES)
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             wired_we,
	input  logic [IDX_W-1:0] wired_value,
	input  logic             advance,
	output logic [IDX_W-1:0] random_index
);

	localparam logic [IDX_W-1:0] TOP = IDX_W'(TLB_ENTRIES - 1);

	logic [IDX_W-1:0] wired_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			wired_q      <= '0;
			random_index <= TOP;
		end else if (wired_we) begin
			wired_q      <= wired_value;
			random_index <= TOP;
		end else if (advance) begin
			// Entries below wired are never picked, so wrap at the wired value.
			if (random_index <= wired_q) begin
				random_index <= TOP;
			end else begin
				random_index <= random_index - 1'b1;
			end
		end
	end

endmodule

//--- logic/tlb_entry_array.sv
`timescale 1ns/1ps

module tlb_entry_array #(
	parameter int TLB_ENTRIES = 16,
	localparam int IDX_W = $clog2(TLB_ENTRIES)
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        we,
	input  logic [IDX_W-1:0]            w_index,
	input  logic [mmu_pkg::ENTRY_W-1:0] w_data,
	input  logic [mmu_pkg::VPN2_W-1:0]  lookup_vpn2,
	input  logic [mmu_pkg::VPN2_W-1:0]  probe_vpn2,
	output logic                        match_hit,
	output logic [IDX_W-1:0]            match_index,
	output logic [mmu_pkg::ENTRY_W-1:0] match_entry,
	output logic                        probe_hit,
	output logic [IDX_W-1:0]            probe_index
);

	import mmu_pkg::*;

	logic [ENTRY_W-1:0] entries [TLB_ENTRIES];

	// Returns {hit, index}. Later indices overwrite earlier ones, so the
	// highest matching entry wins.
	function automatic logic [IDX_W:0] search(input logic [VPN2_W-1:0] vpn2);
		logic             hit;
		logic [IDX_W-1:0] idx;
		hit = 1'b0;
		idx = '0;
		for (int i = 0; i < TLB_ENTRIES; i++) begin
			if (entries[i][VPN2_HI:VPN2_LO] == vpn2) begin
				hit = 1'b1;
				idx = IDX_W'(i);
			end
		end
		return {hit, idx};
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < TLB_ENTRIES; i++) begin
				entries[i] <= '0;
			end
		end else if (we) begin
			entries[w_index] <= w_data;
		end
	end

	always_comb begin
		{match_hit, match_index} = search(lookup_vpn2);
	end

	always_comb begin
		{probe_hit, probe_index} = search(probe_vpn2);
	end

	// On a miss this returns entry 0; the translation stage ignores it then.
	assign match_entry = entries[match_index];

endmodule

//--- logic/mmu_pkg.sv
package mmu_pkg;

	// Bus widths.
	localparam int ADDR_W   = 32;
	localparam int ENTRY_W  = 64;
	localparam int VPN2_W   = 19;
	localparam int PFN_W    = 20;
	localparam int OFFSET_W = 12;

	// Field positions inside one TLB entry.
	localparam int VPN2_HI = 62;
	localparam int VPN2_LO = 44;
	localparam int PFN1_HI = 43;
	localparam int PFN1_LO = 24;
	localparam int D1_BIT  = 23;
	localparam int PFN0_HI = 21;
	localparam int PFN0_LO = 2;
	localparam int D0_BIT  = 1;

	typedef enum logic [1:0] {
		TLB_OP_WI    = 2'd0,
		TLB_OP_WR    = 2'd1,
		TLB_OP_P     = 2'd2,
		TLB_OP_WIRED = 2'd3
	} tlb_op_e;

	typedef enum logic [1:0] {
		EXC_NONE = 2'd0,
		EXC_MOD  = 2'd1,
		EXC_TLBL = 2'd2,
		EXC_TLBS = 2'd3
	} tlb_exc_e;

	// Device select for the memory bus.
	typedef enum logic [2:0] {
		DEV_NONE      = 3'd0,
		DEV_RAM       = 3'd1,
		DEV_ROM       = 3'd2,
		DEV_FLASH     = 3'd3,
		DEV_UART      = 3'd4,
		DEV_UART_STAT = 3'd5,
		DEV_DIGSEG    = 3'd6,
		DEV_PS2       = 3'd7
	} dev_sel_e;

endpackage
